//--- Makefile
TOP = tb_rv_decode_wb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+tests
rtl/rv_isa_pkg.sv
rtl/decode_op_pkg.sv
rtl/rv_op_decode.sv
rtl/rv_field_extract.sv
rtl/decode_wb_regs.sv
rtl/rv_decode_wb.sv
tests/tb_rv_decode_wb.sv

//--- rtl/decode_op_pkg.sv
package decode_op_pkg;

  localparam int alu_op_w = 6;
  localparam int mem_op_w = 4;
  localparam int exc_op_w = 4;
  localparam int pc_op_w  = 3;
  localparam int csr_op_w = 3;
  localparam int trap_w   = 3;
  localparam int wb_adr_w = 3;

  localparam logic [alu_op_w-1:0] alu_none   = 6'd0;
  localparam logic [alu_op_w-1:0] alu_add    = 6'd1;
  localparam logic [alu_op_w-1:0] alu_sub    = 6'd2;
  localparam logic [alu_op_w-1:0] alu_xor    = 6'd3;
  localparam logic [alu_op_w-1:0] alu_or     = 6'd4;
  localparam logic [alu_op_w-1:0] alu_and    = 6'd5;
  localparam logic [alu_op_w-1:0] alu_sll    = 6'd6;
  localparam logic [alu_op_w-1:0] alu_srl    = 6'd7;
  localparam logic [alu_op_w-1:0] alu_sra    = 6'd8;
  localparam logic [alu_op_w-1:0] alu_sllw   = 6'd9;
  localparam logic [alu_op_w-1:0] alu_srlw   = 6'd10;
  localparam logic [alu_op_w-1:0] alu_sraw   = 6'd11;
  localparam logic [alu_op_w-1:0] alu_slt    = 6'd12;
  localparam logic [alu_op_w-1:0] alu_sltu   = 6'd13;
  localparam logic [alu_op_w-1:0] alu_beq    = 6'd14;
  localparam logic [alu_op_w-1:0] alu_bne    = 6'd15;
  localparam logic [alu_op_w-1:0] alu_blt    = 6'd16;
  localparam logic [alu_op_w-1:0] alu_bge    = 6'd17;
  localparam logic [alu_op_w-1:0] alu_bltu   = 6'd18;
  localparam logic [alu_op_w-1:0] alu_bgeu   = 6'd19;
  localparam logic [alu_op_w-1:0] alu_mul    = 6'd20;
  localparam logic [alu_op_w-1:0] alu_mulh   = 6'd21;
  localparam logic [alu_op_w-1:0] alu_mulhsu = 6'd22;
  localparam logic [alu_op_w-1:0] alu_mulhu  = 6'd23;
  localparam logic [alu_op_w-1:0] alu_mulw   = 6'd24;
  localparam logic [alu_op_w-1:0] alu_div    = 6'd25;
  localparam logic [alu_op_w-1:0] alu_divu   = 6'd26;
  localparam logic [alu_op_w-1:0] alu_rem    = 6'd27;
  localparam logic [alu_op_w-1:0] alu_remu   = 6'd28;
  localparam logic [alu_op_w-1:0] alu_divw   = 6'd29;
  localparam logic [alu_op_w-1:0] alu_divuw  = 6'd30;
  localparam logic [alu_op_w-1:0] alu_remw   = 6'd31;
  localparam logic [alu_op_w-1:0] alu_remuw  = 6'd32;

  localparam logic [mem_op_w-1:0] mem_none = 4'd0;
  localparam logic [mem_op_w-1:0] mem_lb   = 4'd1;
  localparam logic [mem_op_w-1:0] mem_lbu  = 4'd2;
  localparam logic [mem_op_w-1:0] mem_lh   = 4'd3;
  localparam logic [mem_op_w-1:0] mem_lw   = 4'd4;
  localparam logic [mem_op_w-1:0] mem_lhu  = 4'd5;
  localparam logic [mem_op_w-1:0] mem_sb   = 4'd6;
  localparam logic [mem_op_w-1:0] mem_sh   = 4'd7;
  localparam logic [mem_op_w-1:0] mem_sw   = 4'd8;
  localparam logic [mem_op_w-1:0] mem_lwu  = 4'd9;
  localparam logic [mem_op_w-1:0] mem_ld   = 4'd10;
  localparam logic [mem_op_w-1:0] mem_sd   = 4'd11;

  localparam logic [exc_op_w-1:0] exc_none    = 4'd0;
  localparam logic [exc_op_w-1:0] exc_auipc   = 4'd1;
  localparam logic [exc_op_w-1:0] exc_lui     = 4'd2;
  localparam logic [exc_op_w-1:0] exc_jal     = 4'd3;
  localparam logic [exc_op_w-1:0] exc_jalr    = 4'd4;
  localparam logic [exc_op_w-1:0] exc_load    = 4'd5;
  localparam logic [exc_op_w-1:0] exc_store   = 4'd6;
  localparam logic [exc_op_w-1:0] exc_branch  = 4'd7;
  localparam logic [exc_op_w-1:0] exc_opimm   = 4'd8;
  localparam logic [exc_op_w-1:0] exc_opimm32 = 4'd9;
  localparam logic [exc_op_w-1:0] exc_op      = 4'd10;
  localparam logic [exc_op_w-1:0] exc_op32    = 4'd11;
  localparam logic [exc_op_w-1:0] exc_csr     = 4'd12;
  localparam logic [exc_op_w-1:0] exc_ebreak  = 4'd13;

  localparam logic [pc_op_w-1:0] pc_inc4   = 3'd0;
  localparam logic [pc_op_w-1:0] pc_branch = 3'd1;
  localparam logic [pc_op_w-1:0] pc_jal    = 3'd2;
  localparam logic [pc_op_w-1:0] pc_jalr   = 3'd3;
  localparam logic [pc_op_w-1:0] pc_trap   = 3'd4;

  localparam logic [csr_op_w-1:0] csr_none  = 3'd0;
  localparam logic [csr_op_w-1:0] csr_read  = 3'd1;
  localparam logic [csr_op_w-1:0] csr_write = 3'd2;
  localparam logic [csr_op_w-1:0] csr_set   = 3'd3;
  localparam logic [csr_op_w-1:0] csr_clear = 3'd4;

  // bit positions in the trap vector
  localparam int trap_ecall  = 0;
  localparam int trap_ebreak = 1;
  localparam int trap_mret   = 2;

  // word addresses seen by the bus
  localparam logic [wb_adr_w-1:0] reg_inst   = 3'd0;
  localparam logic [wb_adr_w-1:0] reg_index  = 3'd1;
  localparam logic [wb_adr_w-1:0] reg_imm_lo = 3'd2;
  localparam logic [wb_adr_w-1:0] reg_imm_hi = 3'd3;
  localparam logic [wb_adr_w-1:0] reg_ops    = 3'd4;

endpackage

//--- rtl/decode_wb_regs.sv
`timescale 1ns/10ps

module decode_wb_regs (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  logic [decode_op_pkg::wb_adr_w-1:0]  wb_adr,
  input  logic [31:0]                         wb_dat_w,
  output logic [31:0]                         wb_dat_r,
  output logic                                wb_ack,
  output rv_isa_pkg::rv_inst_u                inst,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]   rs1_idx,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]   rs2_idx,
  input  logic [rv_isa_pkg::reg_addr_w-1:0]   rd_idx,
  input  logic [rv_isa_pkg::csr_addr_w-1:0]   csr_idx,
  input  logic                                csr_uimm_sel,
  input  logic [rv_isa_pkg::xlen-1:0]         imm,
  input  logic [4:0]                          uimm,
  input  logic [decode_op_pkg::alu_op_w-1:0]  alu_op,
  input  logic [decode_op_pkg::mem_op_w-1:0]  mem_op,
  input  logic [decode_op_pkg::exc_op_w-1:0]  exc_op,
  input  logic [decode_op_pkg::pc_op_w-1:0]   pc_op,
  input  logic [decode_op_pkg::csr_op_w-1:0]  csr_op,
  input  logic [decode_op_pkg::trap_w-1:0]    trap
);

  logic        access;  // new cycle seen, ack goes out next edge
  logic [31:0] rd_word;

  assign access = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      inst   <= '0;
    end else begin
      wb_ack <= access;  // one cycle pulse, access drops while ack is high
      if (access && wb_we && (wb_adr == decode_op_pkg::reg_inst)) inst <= wb_dat_w;
    end
  end

  always_comb begin
    case (wb_adr)
      decode_op_pkg::reg_inst:   rd_word = inst;
      decode_op_pkg::reg_index:  rd_word = {4'b0, csr_uimm_sel, csr_idx, rd_idx, rs2_idx, rs1_idx};
      decode_op_pkg::reg_imm_lo: rd_word = imm[31:0];
      decode_op_pkg::reg_imm_hi: rd_word = imm[63:32];
      decode_op_pkg::reg_ops:
        rd_word = {4'b0, uimm, trap, csr_op, pc_op, exc_op, mem_op, alu_op};
      default:                   rd_word = '0;  // words 5..7
    endcase
  end

  // read data lands together with ack
  always_ff @(posedge clk) begin
    if (access) wb_dat_r <= rd_word;
  end

endmodule

//--- rtl/rv_decode_wb.sv
`timescale 1ns/10ps

module rv_decode_wb (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [decode_op_pkg::wb_adr_w-1:0] wb_adr,
  input  logic [31:0]                        wb_dat_w,
  output logic [31:0]                        wb_dat_r,
  output logic                               wb_ack
);

  rv_isa_pkg::rv_inst_u                inst;
  logic [decode_op_pkg::alu_op_w-1:0]  alu_op;
  logic [decode_op_pkg::mem_op_w-1:0]  mem_op;
  logic [decode_op_pkg::exc_op_w-1:0]  exc_op;
  logic [decode_op_pkg::pc_op_w-1:0]   pc_op;
  logic [decode_op_pkg::csr_op_w-1:0]  csr_op;
  logic [decode_op_pkg::trap_w-1:0]    trap;
  logic [2:0]                          fmt;
  logic                                csr_uimm_sel;
  logic [rv_isa_pkg::reg_addr_w-1:0]   rs1_idx;
  logic [rv_isa_pkg::reg_addr_w-1:0]   rs2_idx;
  logic [rv_isa_pkg::reg_addr_w-1:0]   rd_idx;
  logic [rv_isa_pkg::csr_addr_w-1:0]   csr_idx;
  logic [rv_isa_pkg::xlen-1:0]         imm;
  logic [4:0]                          uimm;

  // bus side, holds the word and muxes the results back
  decode_wb_regs u_decode_wb_regs (.*);

  // both decoders work on the stored word in the same cycle
  rv_op_decode u_rv_op_decode (.*);

  rv_field_extract u_rv_field_extract (.*);

endmodule

//--- rtl/rv_field_extract.sv
`timescale 1ns/10ps

module rv_field_extract (
  input  rv_isa_pkg::rv_inst_u               inst,
  input  logic [2:0]                         fmt,
  input  logic                               csr_uimm_sel,
  output logic [rv_isa_pkg::reg_addr_w-1:0]  rs1_idx,
  output logic [rv_isa_pkg::reg_addr_w-1:0]  rs2_idx,
  output logic [rv_isa_pkg::reg_addr_w-1:0]  rd_idx,
  output logic [rv_isa_pkg::csr_addr_w-1:0]  csr_idx,
  output logic [rv_isa_pkg::xlen-1:0]        imm,
  output logic [4:0]                         uimm
);

  logic [rv_isa_pkg::inst_len-1:0] w;  // flat view for the scattered immediate bits
  logic need_rs1;
  logic need_rs2;
  logic need_rd;
  logic is_csr;

  assign w = inst;

  // uimm sits where rs1 would be
  assign need_rs1 = (fmt inside {rv_isa_pkg::fmt_r, rv_isa_pkg::fmt_i,
                                 rv_isa_pkg::fmt_s, rv_isa_pkg::fmt_b}) && !csr_uimm_sel;
  assign need_rs2 = fmt inside {rv_isa_pkg::fmt_r, rv_isa_pkg::fmt_s, rv_isa_pkg::fmt_b};
  assign need_rd  = fmt inside {rv_isa_pkg::fmt_r, rv_isa_pkg::fmt_i,
                                rv_isa_pkg::fmt_u, rv_isa_pkg::fmt_j};
  assign is_csr   = (inst.i.opcode == rv_isa_pkg::opc_system) && (inst.i.funct3 != 3'b000);

  assign rs1_idx = need_rs1 ? inst.r.rs1 : '0;
  assign rs2_idx = need_rs2 ? inst.r.rs2 : '0;
  assign rd_idx  = need_rd ? inst.r.rd : '0;
  assign csr_idx = is_csr ? inst.i.imm_i : '0;
  assign uimm    = inst.i.rs1;  // zero extended by the consumer

  always_comb begin
    case (fmt)
      rv_isa_pkg::fmt_i: imm = {{52{w[31]}}, inst.i.imm_i};
      rv_isa_pkg::fmt_s: imm = {{52{w[31]}}, w[31:25], w[11:7]};
      rv_isa_pkg::fmt_b: imm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      rv_isa_pkg::fmt_u: imm = {{32{w[31]}}, w[31:12], 12'b0};
      rv_isa_pkg::fmt_j: imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default:           imm = '0;  // r type and invalid words
    endcase
  end

endmodule

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int inst_len   = 32;
  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;
  localparam int csr_addr_w = 12;

  // major opcodes, low two bits always 11
  localparam logic [6:0] opc_load      = 7'b0000011;
  localparam logic [6:0] opc_store     = 7'b0100011;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_jalr      = 7'b1100111;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_system    = 7'b1110011;
  localparam logic [6:0] opc_auipc     = 7'b0010111;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_misc_mem  = 7'b0001111;

  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000;  // sub, sra
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // imm_i of the funct3 000 system instructions
  localparam logic [11:0] sys_ecall  = 12'h000;
  localparam logic [11:0] sys_ebreak = 12'h001;
  localparam logic [11:0] sys_mret   = 12'h302;

  localparam logic [2:0] fmt_none = 3'd0;
  localparam logic [2:0] fmt_r    = 3'd1;
  localparam logic [2:0] fmt_i    = 3'd2;
  localparam logic [2:0] fmt_s    = 3'd3;
  localparam logic [2:0] fmt_b    = 3'd4;
  localparam logic [2:0] fmt_u    = 3'd5;
  localparam logic [2:0] fmt_j    = 3'd6;

  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [csr_addr_w-1:0] imm_i;  // also the csr address
      logic [reg_addr_w-1:0] rs1;    // uimm in the csr*i forms
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } rv_inst_u;

endpackage

//--- rtl/rv_op_decode.sv
`timescale 1ns/10ps

module rv_op_decode (
  input  rv_isa_pkg::rv_inst_u                inst,
  output logic [decode_op_pkg::alu_op_w-1:0] alu_op,
  output logic [decode_op_pkg::mem_op_w-1:0] mem_op,
  output logic [decode_op_pkg::exc_op_w-1:0] exc_op,
  output logic [decode_op_pkg::pc_op_w-1:0]  pc_op,
  output logic [decode_op_pkg::csr_op_w-1:0] csr_op,
  output logic [decode_op_pkg::trap_w-1:0]   trap,
  output logic [2:0]                         fmt,
  output logic                               csr_uimm_sel
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [6:0] funct7_sh;  // rv64 shifts, shamt[5] masked out
  logic       is_priv;
  logic       is_ecall;
  logic       is_ebreak;
  logic       is_mret;
  logic       is_csr;
  logic       is_csrw;
  logic       is_csrs;
  logic       is_csrc;

  assign opcode    = inst.r.opcode;
  assign funct3    = inst.r.funct3;
  assign funct7    = inst.r.funct7;
  assign funct7_sh = {inst.r.funct7[6:1], 1'b0};

  assign is_priv   = (opcode == rv_isa_pkg::opc_system) && (funct3 == 3'b000);
  assign is_ecall  = is_priv && (inst.i.imm_i == rv_isa_pkg::sys_ecall);
  assign is_ebreak = is_priv && (inst.i.imm_i == rv_isa_pkg::sys_ebreak);
  assign is_mret   = is_priv && (inst.i.imm_i == rv_isa_pkg::sys_mret);
  // funct3 000 and 100 are not csr ops
  assign is_csr    = (opcode == rv_isa_pkg::opc_system) && (funct3[1:0] != 2'b00);
  assign is_csrw   = is_csr && (funct3[1:0] == 2'b01);
  assign is_csrs   = is_csr && (funct3[1:0] == 2'b10);
  assign is_csrc   = is_csr && (funct3[1:0] == 2'b11);

  assign csr_uimm_sel = is_csr && funct3[2];

  assign trap[decode_op_pkg::trap_ecall]  = is_ecall;
  assign trap[decode_op_pkg::trap_ebreak] = is_ebreak;
  assign trap[decode_op_pkg::trap_mret]   = is_mret;

  always_comb begin
    // set or clear from x0 / zero uimm only reads
    if ((is_csrs || is_csrc) && (inst.i.rs1 == '0)) csr_op = decode_op_pkg::csr_read;
    else if (is_csrw) csr_op = decode_op_pkg::csr_write;
    else if (is_csrs) csr_op = decode_op_pkg::csr_set;
    else if (is_csrc) csr_op = decode_op_pkg::csr_clear;
    else csr_op = decode_op_pkg::csr_none;
  end

  always_comb begin
    alu_op = decode_op_pkg::alu_none;
    mem_op = decode_op_pkg::mem_none;
    exc_op = decode_op_pkg::exc_none;
    pc_op  = decode_op_pkg::pc_inc4;
    fmt    = rv_isa_pkg::fmt_none;
    case (opcode)
      rv_isa_pkg::opc_lui, rv_isa_pkg::opc_auipc: begin
        fmt    = rv_isa_pkg::fmt_u;
        alu_op = decode_op_pkg::alu_add;
        exc_op = (opcode == rv_isa_pkg::opc_lui) ? decode_op_pkg::exc_lui
                                                 : decode_op_pkg::exc_auipc;
      end
      rv_isa_pkg::opc_jal: begin
        fmt    = rv_isa_pkg::fmt_j;
        exc_op = decode_op_pkg::exc_jal;
        alu_op = decode_op_pkg::alu_add;  // link address pc+4
        pc_op  = decode_op_pkg::pc_jal;
      end
      rv_isa_pkg::opc_jalr: begin
        fmt    = rv_isa_pkg::fmt_i;
        exc_op = decode_op_pkg::exc_jalr;
        if (funct3 == 3'b000) begin
          alu_op = decode_op_pkg::alu_add;
          pc_op  = decode_op_pkg::pc_jalr;
        end
      end
      rv_isa_pkg::opc_branch: begin
        fmt    = rv_isa_pkg::fmt_b;
        exc_op = decode_op_pkg::exc_branch;
        pc_op  = decode_op_pkg::pc_branch;  // even for the reserved funct3 values
        case (funct3)
          3'b000:  alu_op = decode_op_pkg::alu_beq;
          3'b001:  alu_op = decode_op_pkg::alu_bne;
          3'b100:  alu_op = decode_op_pkg::alu_blt;
          3'b101:  alu_op = decode_op_pkg::alu_bge;
          3'b110:  alu_op = decode_op_pkg::alu_bltu;
          3'b111:  alu_op = decode_op_pkg::alu_bgeu;
          default: ;
        endcase
      end
      rv_isa_pkg::opc_load: begin
        fmt    = rv_isa_pkg::fmt_i;
        exc_op = decode_op_pkg::exc_load;
        alu_op = decode_op_pkg::alu_add;  // address rs1+imm
        case (funct3)
          3'b000:  mem_op = decode_op_pkg::mem_lb;
          3'b001:  mem_op = decode_op_pkg::mem_lh;
          3'b010:  mem_op = decode_op_pkg::mem_lw;
          3'b011:  mem_op = decode_op_pkg::mem_ld;
          3'b100:  mem_op = decode_op_pkg::mem_lbu;
          3'b101:  mem_op = decode_op_pkg::mem_lhu;
          3'b110:  mem_op = decode_op_pkg::mem_lwu;
          default: ;
        endcase
      end
      rv_isa_pkg::opc_store: begin
        fmt    = rv_isa_pkg::fmt_s;
        exc_op = decode_op_pkg::exc_store;
        alu_op = decode_op_pkg::alu_add;
        case (funct3)
          3'b000:  mem_op = decode_op_pkg::mem_sb;
          3'b001:  mem_op = decode_op_pkg::mem_sh;
          3'b010:  mem_op = decode_op_pkg::mem_sw;
          3'b011:  mem_op = decode_op_pkg::mem_sd;
          default: ;
        endcase
      end
      rv_isa_pkg::opc_op_imm: begin
        fmt    = rv_isa_pkg::fmt_i;
        exc_op = decode_op_pkg::exc_opimm;
        case (funct3)
          3'b000: alu_op = decode_op_pkg::alu_add;
          3'b010: alu_op = decode_op_pkg::alu_slt;
          3'b011: alu_op = decode_op_pkg::alu_sltu;
          3'b100: alu_op = decode_op_pkg::alu_xor;
          3'b110: alu_op = decode_op_pkg::alu_or;
          3'b111: alu_op = decode_op_pkg::alu_and;
          3'b001: if (funct7_sh == rv_isa_pkg::funct7_base) alu_op = decode_op_pkg::alu_sll;
          default: begin
            if (funct7_sh == rv_isa_pkg::funct7_base) alu_op = decode_op_pkg::alu_srl;
            else if (funct7_sh == rv_isa_pkg::funct7_alt) alu_op = decode_op_pkg::alu_sra;
          end
        endcase
      end
      rv_isa_pkg::opc_op_imm_32: begin
        fmt    = rv_isa_pkg::fmt_i;
        exc_op = decode_op_pkg::exc_opimm32;
        if (funct3 == 3'b000) alu_op = decode_op_pkg::alu_add;
        else if (funct7 == rv_isa_pkg::funct7_base && funct3 == 3'b001)
          alu_op = decode_op_pkg::alu_sllw;
        else if (funct7 == rv_isa_pkg::funct7_base && funct3 == 3'b101)
          alu_op = decode_op_pkg::alu_srlw;
        else if (funct7 == rv_isa_pkg::funct7_alt && funct3 == 3'b101)
          alu_op = decode_op_pkg::alu_sraw;
      end
      rv_isa_pkg::opc_op: begin
        fmt    = rv_isa_pkg::fmt_r;
        exc_op = decode_op_pkg::exc_op;
        if (funct7 == rv_isa_pkg::funct7_muldiv) begin
          case (funct3)
            3'b000:  alu_op = decode_op_pkg::alu_mul;
            3'b001:  alu_op = decode_op_pkg::alu_mulh;
            3'b010:  alu_op = decode_op_pkg::alu_mulhsu;
            3'b011:  alu_op = decode_op_pkg::alu_mulhu;
            3'b100:  alu_op = decode_op_pkg::alu_div;
            3'b101:  alu_op = decode_op_pkg::alu_divu;
            3'b110:  alu_op = decode_op_pkg::alu_rem;
            default: alu_op = decode_op_pkg::alu_remu;
          endcase
        end else if (funct7 == rv_isa_pkg::funct7_base) begin
          case (funct3)
            3'b000:  alu_op = decode_op_pkg::alu_add;
            3'b001:  alu_op = decode_op_pkg::alu_sll;
            3'b010:  alu_op = decode_op_pkg::alu_slt;
            3'b011:  alu_op = decode_op_pkg::alu_sltu;
            3'b100:  alu_op = decode_op_pkg::alu_xor;
            3'b101:  alu_op = decode_op_pkg::alu_srl;
            3'b110:  alu_op = decode_op_pkg::alu_or;
            default: alu_op = decode_op_pkg::alu_and;
          endcase
        end else if (funct7 == rv_isa_pkg::funct7_alt) begin
          if (funct3 == 3'b000) alu_op = decode_op_pkg::alu_sub;
          else if (funct3 == 3'b101) alu_op = decode_op_pkg::alu_sra;
        end
      end
      rv_isa_pkg::opc_op_32: begin
        fmt    = rv_isa_pkg::fmt_r;
        exc_op = decode_op_pkg::exc_op32;
        if (funct7 == rv_isa_pkg::funct7_muldiv) begin
          case (funct3)
            3'b000:  alu_op = decode_op_pkg::alu_mulw;
            3'b100:  alu_op = decode_op_pkg::alu_divw;
            3'b101:  alu_op = decode_op_pkg::alu_divuw;
            3'b110:  alu_op = decode_op_pkg::alu_remw;
            3'b111:  alu_op = decode_op_pkg::alu_remuw;
            default: ;
          endcase
        end else if (funct7 == rv_isa_pkg::funct7_base) begin
          if (funct3 == 3'b000) alu_op = decode_op_pkg::alu_add;
          else if (funct3 == 3'b001) alu_op = decode_op_pkg::alu_sllw;
          else if (funct3 == 3'b101) alu_op = decode_op_pkg::alu_srlw;
        end else if (funct7 == rv_isa_pkg::funct7_alt) begin
          if (funct3 == 3'b000) alu_op = decode_op_pkg::alu_sub;
          else if (funct3 == 3'b101) alu_op = decode_op_pkg::alu_sraw;
        end
      end
      rv_isa_pkg::opc_system: begin
        fmt = rv_isa_pkg::fmt_i;
        if (is_ebreak) exc_op = decode_op_pkg::exc_ebreak;
        else if (is_csr) exc_op = decode_op_pkg::exc_csr;
        if (is_csr) alu_op = decode_op_pkg::alu_add;
        if (is_mret || is_ecall) pc_op = decode_op_pkg::pc_trap;
      end
      rv_isa_pkg::opc_misc_mem: ;  // fence goes through as a nop
      default: ;
    endcase
  end

endmodule

//--- tests/tb_decode_tasks.svh
task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERROR at %0t: %s read %h, expected %h", $time, what, got, exp);
  end
endtask

// one clock per try, called 1 ns after an edge
task automatic wait_ack(input logic [decode_op_pkg::wb_adr_w-1:0] adr);
  int waited;
  waited = 0;
  do begin
    @(posedge clk);
    #1;
    waited++;
  end while (!wb_ack && waited < 8);
  if (!wb_ack) begin
    errors++;
    $display("no ack from the DUT within 8 cycles for word %0d", adr);
  end
endtask

task automatic wb_write(input logic [decode_op_pkg::wb_adr_w-1:0] adr, input logic [31:0] data);
  wb_cyc   = 1'b1;
  wb_stb   = 1'b1;
  wb_we    = 1'b1;
  wb_adr   = adr;
  wb_dat_w = data;
  wait_ack(adr);
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we  = 1'b0;
endtask

task automatic wb_read(input logic [decode_op_pkg::wb_adr_w-1:0] adr, output logic [31:0] data);
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we  = 1'b0;
  wb_adr = adr;
  wait_ack(adr);
  data   = wb_dat_r;  // registered with ack
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
endtask

// word 4 layout
function automatic logic [31:0] ops_word(input logic [5:0] alu, input logic [3:0] mem,
                                         input logic [3:0] exc, input logic [2:0] pc,
                                         input logic [2:0] csr, input logic [2:0] trap,
                                         input logic [4:0] uimm);
  return {4'b0, uimm, trap, csr, pc, exc, mem, alu};
endfunction

// word 1 layout
function automatic logic [31:0] index_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [4:0] rd, input logic [11:0] csr,
                                           input logic flag);
  return {4'b0, flag, csr, rd, rs2, rs1};
endfunction

task automatic decode_all(input string name, input logic [31:0] word, input logic [31:0] exp_index,
                          input logic [63:0] exp_imm, input logic [31:0] exp_ops);
  logic [31:0] got;
  wb_write(decode_op_pkg::reg_inst, word);
  wb_read(decode_op_pkg::reg_inst, got);
  check_word({name, " inst"}, got, word);
  wb_read(decode_op_pkg::reg_index, got);
  check_word({name, " index"}, got, exp_index);
  wb_read(decode_op_pkg::reg_imm_lo, got);
  check_word({name, " imm lo"}, got, exp_imm[31:0]);
  wb_read(decode_op_pkg::reg_imm_hi, got);
  check_word({name, " imm hi"}, got, exp_imm[63:32]);
  wb_read(decode_op_pkg::reg_ops, got);
  check_word({name, " ops"}, got, exp_ops);
endtask

task automatic decode_ops(input string name, input logic [31:0] word, input logic [31:0] exp_ops);
  logic [31:0] got;
  wb_write(decode_op_pkg::reg_inst, word);
  wb_read(decode_op_pkg::reg_ops, got);
  check_word({name, " ops"}, got, exp_ops);
endtask

task automatic test_reset_state();
  logic [31:0] got;
  wb_read(decode_op_pkg::reg_ops, got);
  check_word("reset ops", got, ops_word(decode_op_pkg::alu_none, decode_op_pkg::mem_none,
             decode_op_pkg::exc_none, decode_op_pkg::pc_inc4, decode_op_pkg::csr_none,
             3'b000, 5'd0));
  wb_read(decode_op_pkg::reg_inst, got);
  check_word("reset inst", got, 32'h0);
endtask

task automatic test_r_type();
  logic [31:0] idx;
  idx = index_word(5'd12, 5'd7, 5'd25, 12'h000, 1'b0);
  decode_all("add", {7'b0000000, 5'd7, 5'd12, 3'b000, 5'd25, rv_isa_pkg::opc_op}, idx, 64'd0,
             ops_word(decode_op_pkg::alu_add, 4'd0, decode_op_pkg::exc_op, 3'd0, 3'd0,
                      3'b000, 5'd12));
  decode_all("sub", {7'b0100000, 5'd7, 5'd12, 3'b000, 5'd25, rv_isa_pkg::opc_op}, idx, 64'd0,
             ops_word(decode_op_pkg::alu_sub, 4'd0, decode_op_pkg::exc_op, 3'd0, 3'd0,
                      3'b000, 5'd12));
  decode_all("sraw", {7'b0100000, 5'd7, 5'd12, 3'b101, 5'd25, rv_isa_pkg::opc_op_32}, idx,
             64'd0, ops_word(decode_op_pkg::alu_sraw, 4'd0, decode_op_pkg::exc_op32, 3'd0,
                             3'd0, 3'b000, 5'd12));
  decode_all("mulw", {7'b0000001, 5'd7, 5'd12, 3'b000, 5'd25, rv_isa_pkg::opc_op_32}, idx,
             64'd0, ops_word(decode_op_pkg::alu_mulw, 4'd0, decode_op_pkg::exc_op32, 3'd0,
                             3'd0, 3'b000, 5'd12));
endtask

task automatic test_imm_formats();
  logic [31:0] r;
  logic [31:0] word;
  logic [11:0] imm12;
  logic [12:0] imm13;
  logic [19:0] imm20;
  logic [20:0] imm21;
  repeat (4) begin
    r     = $random(seed);
    imm12 = r[11:0];
    word  = {imm12, 5'd3, 3'b000, 5'd9, rv_isa_pkg::opc_op_imm};  // addi
    decode_all("addi", word, index_word(5'd3, 5'd0, 5'd9, 12'h000, 1'b0),
               {{52{imm12[11]}}, imm12},
               ops_word(decode_op_pkg::alu_add, 4'd0, decode_op_pkg::exc_opimm, 3'd0, 3'd0,
                        3'b000, 5'd3));
    r     = $random(seed);
    imm12 = r[11:0];
    word  = {imm12[11:5], 5'd4, 5'd3, 3'b011, imm12[4:0], rv_isa_pkg::opc_store};  // sd
    decode_all("sd", word, index_word(5'd3, 5'd4, 5'd0, 12'h000, 1'b0),
               {{52{imm12[11]}}, imm12},
               ops_word(decode_op_pkg::alu_add, decode_op_pkg::mem_sd, decode_op_pkg::exc_store,
                        3'd0, 3'd0, 3'b000, 5'd3));
    r     = $random(seed);
    imm13 = {r[12:1], 1'b0};
    word  = {imm13[12], imm13[10:5], 5'd4, 5'd3, 3'b000, imm13[4:1], imm13[11],
             rv_isa_pkg::opc_branch};
    decode_all("beq", word, index_word(5'd3, 5'd4, 5'd0, 12'h000, 1'b0),
               {{51{imm13[12]}}, imm13},
               ops_word(decode_op_pkg::alu_beq, 4'd0, decode_op_pkg::exc_branch,
                        decode_op_pkg::pc_branch, 3'd0, 3'b000, 5'd3));
    r     = $random(seed);
    imm20 = r[19:0];
    word  = {imm20, 5'd9, rv_isa_pkg::opc_lui};
    decode_all("lui", word, index_word(5'd0, 5'd0, 5'd9, 12'h000, 1'b0),
               {{32{imm20[19]}}, imm20, 12'h000},
               ops_word(decode_op_pkg::alu_add, 4'd0, decode_op_pkg::exc_lui, 3'd0, 3'd0,
                        3'b000, word[19:15]));  // uimm field is just bits 19:15
    r     = $random(seed);
    imm21 = {r[20:1], 1'b0};
    word  = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], 5'd9, rv_isa_pkg::opc_jal};
    decode_all("jal", word, index_word(5'd0, 5'd0, 5'd9, 12'h000, 1'b0),
               {{43{imm21[20]}}, imm21},
               ops_word(decode_op_pkg::alu_add, 4'd0, decode_op_pkg::exc_jal,
                        decode_op_pkg::pc_jal, 3'd0, 3'b000, word[19:15]));
  end
endtask

task automatic test_mem_branch();
  logic [3:0] load_mem [7];
  logic [3:0] store_mem [4];
  logic [2:0] br_f3 [6];
  logic [5:0] br_alu [6];
  int         k;
  // indexed by funct3
  load_mem  = '{decode_op_pkg::mem_lb, decode_op_pkg::mem_lh, decode_op_pkg::mem_lw,
                decode_op_pkg::mem_ld, decode_op_pkg::mem_lbu, decode_op_pkg::mem_lhu,
                decode_op_pkg::mem_lwu};
  store_mem = '{decode_op_pkg::mem_sb, decode_op_pkg::mem_sh, decode_op_pkg::mem_sw,
                decode_op_pkg::mem_sd};
  br_f3     = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  br_alu    = '{decode_op_pkg::alu_beq, decode_op_pkg::alu_bne, decode_op_pkg::alu_blt,
                decode_op_pkg::alu_bge, decode_op_pkg::alu_bltu, decode_op_pkg::alu_bgeu};
  for (k = 0; k < 7; k++) begin
    decode_ops("load", {12'h010, 5'd2, k[2:0], 5'd5, rv_isa_pkg::opc_load},
               ops_word(decode_op_pkg::alu_add, load_mem[k], decode_op_pkg::exc_load, 3'd0,
                        3'd0, 3'b000, 5'd2));
  end
  for (k = 0; k < 4; k++) begin
    decode_ops("store", {7'h00, 5'd6, 5'd2, k[2:0], 5'd8, rv_isa_pkg::opc_store},
               ops_word(decode_op_pkg::alu_add, store_mem[k], decode_op_pkg::exc_store, 3'd0,
                        3'd0, 3'b000, 5'd2));
  end
  for (k = 0; k < 6; k++) begin
    decode_ops("branch", {7'h00, 5'd6, 5'd2, br_f3[k], 5'h10, rv_isa_pkg::opc_branch},
               ops_word(br_alu[k], 4'd0, decode_op_pkg::exc_branch, decode_op_pkg::pc_branch,
                        3'd0, 3'b000, 5'd2));
  end
endtask

task automatic test_csr();
  logic [31:0] r;
  logic [11:0] csr_adr;
  r       = $random(seed);
  csr_adr = r[11:0];
  decode_all("csrrw", {12'h305, 5'd6, 3'b001, 5'd5, rv_isa_pkg::opc_system},
             index_word(5'd6, 5'd0, 5'd5, 12'h305, 1'b0), 64'h305,
             ops_word(decode_op_pkg::alu_add, 4'd0, decode_op_pkg::exc_csr, 3'd0,
                      decode_op_pkg::csr_write, 3'b000, 5'd6));
  // immediate form, rs1 slot carries uimm 9
  decode_all("csrrsi", {csr_adr, 5'd9, 3'b110, 5'd7, rv_isa_pkg::opc_system},
             index_word(5'd0, 5'd0, 5'd7, csr_adr, 1'b1), {{52{csr_adr[11]}}, csr_adr},
             ops_word(decode_op_pkg::alu_add, 4'd0, decode_op_pkg::exc_csr, 3'd0,
                      decode_op_pkg::csr_set, 3'b000, 5'd9));
  decode_all("csrrs x0", {12'hf14, 5'd0, 3'b010, 5'd3, rv_isa_pkg::opc_system},
             index_word(5'd0, 5'd0, 5'd3, 12'hf14, 1'b0), 64'hffff_ffff_ffff_ff14,
             ops_word(decode_op_pkg::alu_add, 4'd0, decode_op_pkg::exc_csr, 3'd0,
                      decode_op_pkg::csr_read, 3'b000, 5'd0));
endtask

task automatic test_traps();
  // trap bits: ecall 0, ebreak 1, mret 2
  decode_ops("ecall", {12'h000, 5'd0, 3'b000, 5'd0, rv_isa_pkg::opc_system},
             ops_word(6'd0, 4'd0, decode_op_pkg::exc_none, decode_op_pkg::pc_trap, 3'd0,
                      3'b001, 5'd0));
  decode_ops("ebreak", {12'h001, 5'd0, 3'b000, 5'd0, rv_isa_pkg::opc_system},
             ops_word(6'd0, 4'd0, decode_op_pkg::exc_ebreak, decode_op_pkg::pc_inc4, 3'd0,
                      3'b010, 5'd0));
  decode_ops("mret", {12'h302, 5'd0, 3'b000, 5'd0, rv_isa_pkg::opc_system},
             ops_word(6'd0, 4'd0, decode_op_pkg::exc_none, decode_op_pkg::pc_trap, 3'd0,
                      3'b100, 5'd0));
endtask

//--- tests/tb_rv_decode_wb.sv
`timescale 1ns/10ps

module tb_rv_decode_wb;

  localparam int max_cycles = 2000;  // roughly four times a normal run

  logic                               clk;
  logic                               reset;
  logic                               wb_cyc;
  logic                               wb_stb;
  logic                               wb_we;
  logic [decode_op_pkg::wb_adr_w-1:0] wb_adr;
  logic [31:0]                        wb_dat_w;
  logic [31:0]                        wb_dat_r;
  logic                               wb_ack;

  integer seed;  // for the random immediates
  int     errors;
  int     checks;
  int     cycle_count;

  rv_decode_wb u_rv_decode_wb (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #2 clk = ~clk;  // 4 ns period

  `include "tb_decode_tasks.svh"

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    seed     = 32'h9dcf9a76;
    errors   = 0;
    checks   = 0;

    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;  // inputs move 1 ns after the edge

    test_reset_state();
    test_r_type();
    test_imm_formats();
    test_mem_branch();
    test_csr();
    test_traps();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
